// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_decode
SEED      ?= 42
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

// File: tb.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/frontend_pkg.sv
verilog/program_counter.sv
verilog/fetch_control.sv
verilog/instruction_register.sv
verilog/immediate_gen.sv
verilog/fetch_decode_top.sv
tb/clock_gen.sv
tb/tb_fetch_decode.sv

// File: tb/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0; // Released on a falling edge like the other inputs
  end

endmodule

// File: tb/tb_fetch_decode.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_fetch_decode #(
  parameter int SEED = 42
);

  import frontend_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int AW          = 10; // Word address bits of the memory model
  localparam int MEM_WORDS   = 1 << AW;
  localparam int N_OPC       = 11;
  localparam int N_F7        = 5;
  localparam int N_SYS       = 10;
  localparam int N_DIR       = N_OPC * 8 * N_F7 + N_SYS;
  localparam int N_RAND      = 300;
  localparam int N_TOTAL     = N_DIR + N_RAND;
  localparam int WATCHDOG_NS = (N_TOTAL * 12 + 100) * CLK_PERIOD;

  localparam logic [6:0] OPCODES [N_OPC] = '{7'b0110011, 7'b0010011, 7'b0000011,
    7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111,
    7'b1110011, 7'b0101111};
  // 04 gives the AMOSWAP funct5, 7F sets the sign bit of every immediate
  localparam logic [6:0] FUNCT7S [N_F7] = '{7'h00, 7'h20, 7'h01, 7'h04, 7'h7F};
  // Privileged words, then URET and three unknown opcodes
  localparam logic [31:0] SYS_WORDS [N_SYS] = '{32'h0000_0073, 32'h0010_0073,
    32'h1020_0073, 32'h3020_0073, 32'h1050_0073, 32'h1200_0073, 32'h0020_0073,
    32'h0000_007F, 32'h0000_000F, 32'h0000_0000};

  typedef struct packed {
    logic [7:0]  id;
    logic [31:0] imm;
  } ref_result_t;

  logic             clk;
  logic             reset;
  logic             imem_req_valid;
  logic [`XLEN-1:0] imem_addr;
  logic             imem_req_ready;
  logic             imem_rsp_valid;
  logic [`XLEN-1:0] imem_rsp_data;
  logic             issue_valid;
  issue_pkt_t       issue;
  logic             issue_ready;
  logic             redirect_valid;
  logic [`XLEN-1:0] redirect_pc;

  logic [31:0]      mem [0:MEM_WORDS-1];
  logic             seen [0:255];
  logic [31:0]      exp_pc = `RESET_PC;
  logic [31:0]      fetch_addr;
  logic             req_taken = 1'b0;
  logic             req_expected = 1'b1;
  int               rsp_wait = 0;
  int               cycle = 0;
  int               rsp_cycle = 0;
  int               issued = 0;
  int               checks = 0;
  int               errors = 0;
  int               cur_checks = 0;
  int               cur_errors = 0;
  int               tests_run = 0;
  string            cur_test = "directed";
  logic             valid_q = 1'b0;
  logic             stall_q = 1'b0;
  issue_pkt_t       held;

  clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clk (
    .clk   (clk),
    .reset (reset)
  );

  fetch_decode_top UUT (
    .clk            (clk),
    .reset          (reset),
    .imem_req_valid (imem_req_valid),
    .imem_addr      (imem_addr),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rsp_data  (imem_rsp_data),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .issue_ready    (issue_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  // Expected identity and immediate straight from the RV32 encodings
  function automatic ref_result_t decode_ref(input logic [31:0] w);
    logic [16:0]        key;
    logic signed [31:0] t;
    ref_result_t        r;
    key  = {w[31:25], w[14:12], w[6:0]};
    r.id = 8'd255;
    case (w)
      32'h0000_0073: r.id = 8'd53;
      32'h0010_0073: r.id = 8'd54;
      32'h1020_0073: r.id = 8'd56;
      32'h3020_0073: r.id = 8'd57;
      32'h1050_0073: r.id = 8'd58;
      32'h1200_0073: r.id = 8'd59;
      default: begin
        casez (key)
          17'b0000000_000_0110011: r.id = 8'd0;
          17'b0100000_000_0110011: r.id = 8'd1;
          17'b0000000_001_0110011: r.id = 8'd2;
          17'b0000000_010_0110011: r.id = 8'd3;
          17'b0000000_011_0110011: r.id = 8'd4;
          17'b0000000_100_0110011: r.id = 8'd5;
          17'b0000000_101_0110011: r.id = 8'd6;
          17'b0100000_101_0110011: r.id = 8'd7;
          17'b0000000_110_0110011: r.id = 8'd8;
          17'b0000000_111_0110011: r.id = 8'd9;
          17'b0000001_???_0110011: r.id = 8'd10 + 8'(w[14:12]); // MUL to REMU in funct3 order
          17'b???????_000_0010011: r.id = 8'd18;
          17'b???????_010_0010011: r.id = 8'd19;
          17'b???????_011_0010011: r.id = 8'd20;
          17'b???????_100_0010011: r.id = 8'd21;
          17'b???????_110_0010011: r.id = 8'd22;
          17'b???????_111_0010011: r.id = 8'd23;
          17'b0000000_001_0010011: r.id = 8'd24;
          17'b0000000_101_0010011: r.id = 8'd25;
          17'b0100000_101_0010011: r.id = 8'd26;
          17'b???????_000_0000011: r.id = 8'd27;
          17'b???????_001_0000011: r.id = 8'd28;
          17'b???????_010_0000011: r.id = 8'd29;
          17'b???????_100_0000011: r.id = 8'd30;
          17'b???????_101_0000011: r.id = 8'd31;
          17'b???????_000_0100011: r.id = 8'd32;
          17'b???????_001_0100011: r.id = 8'd33;
          17'b???????_010_0100011: r.id = 8'd34;
          17'b???????_000_1100011: r.id = 8'd35;
          17'b???????_001_1100011: r.id = 8'd36;
          17'b???????_100_1100011: r.id = 8'd37;
          17'b???????_101_1100011: r.id = 8'd38;
          17'b???????_110_1100011: r.id = 8'd39;
          17'b???????_111_1100011: r.id = 8'd40;
          17'b???????_???_1101111: r.id = 8'd41;
          17'b???????_000_1100111: r.id = 8'd42;
          17'b???????_???_0110111: r.id = 8'd43;
          17'b???????_???_0010111: r.id = 8'd44;
          17'b???????_001_1110011: r.id = 8'd45;
          17'b???????_010_1110011: r.id = 8'd46;
          17'b???????_011_1110011: r.id = 8'd47;
          17'b???????_101_1110011: r.id = 8'd48;
          17'b???????_110_1110011: r.id = 8'd49;
          17'b???????_111_1110011: r.id = 8'd50;
          17'b00001??_010_0101111: r.id = 8'd60;
          default: r.id = 8'd255;
        endcase
      end
    endcase
    // Immediate follows the opcode alone, arithmetic shifts do the sign extension
    case (w[6:0])
      7'b0010011, 7'b0000011, 7'b1100111: begin
        t     = w;
        r.imm = t >>> 20;
      end
      7'b0100011: begin
        t     = {w[31:25], w[11:7], 20'b0};
        r.imm = t >>> 20;
      end
      7'b1100011: begin
        t     = {w[31], w[7], w[30:25], w[11:8], 20'b0};
        r.imm = t >>> 19;
      end
      7'b1101111: begin
        t     = {w[31], w[19:12], w[20], w[30:21], 12'b0};
        r.imm = t >>> 11;
      end
      7'b0110111, 7'b0010111: r.imm = {w[31:12], 12'b0};
      7'b1110011: begin
        t = w;
        if (w[14]) r.imm = {27'b0, w[19:15]}; // CSR uimm
        else if (w[13:12] != 2'b00) r.imm = t >>> 20;
        else r.imm = 32'b0;
      end
      default: r.imm = 32'b0;
    endcase
    return r;
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    cur_checks++;
    if (expected !== actual) begin
      errors++;
      cur_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %-9s %0d checks, %0d errors", name, cur_checks, cur_errors);
    cur_checks = 0;
    cur_errors = 0;
    tests_run++;
  endtask

  // Compares one transferred packet with the model and advances the expected pc
  task automatic check_issue();
    logic [31:0] raw;
    ref_result_t r;
    raw = mem[exp_pc[AW+1:2]];
    r   = decode_ref(raw);
    check_value(cur_test, "pc", exp_pc, issue.pc);
    check_value(cur_test, "raw", raw, issue.raw);
    check_value(cur_test, "id", 32'(r.id), 32'(issue.id));
    check_value(cur_test, "rd", 32'(raw[11:7]), 32'(issue.rd));
    check_value(cur_test, "rs1", 32'(raw[19:15]), 32'(issue.rs1));
    check_value(cur_test, "rs2", 32'(raw[24:20]), 32'(issue.rs2));
    check_value(cur_test, "imm", r.imm, issue.imm);
    if (issued < N_DIR) seen[issue.id] = 1'b1;
    exp_pc = redirect_valid ? redirect_pc : exp_pc + 32'd4;
    issued++;
    if (issued == N_DIR) begin
      report_test("directed");
      cur_test = "redirect";
    end
  endtask

  // Memory and execute-side models
  always @(negedge clk) begin
    imem_req_ready = ($urandom_range(0, 3) != 0);
    issue_ready    = ($urandom_range(0, 2) != 0);
    redirect_valid = (issued >= N_DIR) && ($urandom_range(0, 3) == 0);
    redirect_pc    = $urandom_range(0, MEM_WORDS - 1) * 4;
    if (req_taken) begin
      rsp_wait  = $urandom_range(1, 4);
      req_taken = 1'b0;
    end
    imem_rsp_valid = 1'b0;
    imem_rsp_data  = $urandom; // Junk outside the pulse
    if (rsp_wait != 0) begin
      rsp_wait--;
      if (rsp_wait == 0) begin
        imem_rsp_valid = 1'b1;
        imem_rsp_data  = mem[fetch_addr[AW+1:2]];
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycle++;
      if (imem_rsp_valid) rsp_cycle = cycle;
      check_value(cur_test, "req_valid", 32'(req_expected), 32'(imem_req_valid));
      if (imem_req_valid) begin
        check_value(cur_test, "imem_addr", exp_pc, imem_addr);
      end
      if (imem_req_valid && imem_req_ready) begin
        fetch_addr   = imem_addr;
        req_taken    = 1'b1;
        req_expected = 1'b0; // One fetch outstanding until the issue transfer
      end
      if (issue_valid && !valid_q) begin
        check_value(cur_test, "issue_lag", 32'd2, cycle - rsp_cycle);
      end
      if (stall_q) begin
        if (!issue_valid) begin
          errors++;
          cur_errors++;
          $display("[ERROR] %s: issue_valid dropped while the packet was stalled", cur_test);
        end else begin
          check_value(cur_test, "held_pc", held.pc, issue.pc);
          check_value(cur_test, "held_raw", held.raw, issue.raw);
          check_value(cur_test, "held_imm", held.imm, issue.imm);
          check_value(cur_test, "held_fields", 32'({held.id, held.rd, held.rs1, held.rs2}),
                      32'({issue.id, issue.rd, issue.rs1, issue.rs2}));
        end
      end
      if (issue_valid && issue_ready) begin
        check_issue();
        req_expected = 1'b1;
      end
      valid_q = issue_valid;
      stall_q = issue_valid && !issue_ready;
      held    = issue;
    end
  end

  initial begin
    int n;
    imem_req_ready = 1'b0;
    imem_rsp_valid = 1'b0;
    imem_rsp_data  = '0;
    issue_ready    = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) seen[i] = 1'b0;
    n = 0;
    for (int o = 0; o < N_OPC; o++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int k = 0; k < N_F7; k++) begin
          mem[n] = {FUNCT7S[k], 5'($urandom), 5'($urandom), 3'(f3), 5'($urandom), OPCODES[o]};
          n++;
        end
      end
    end
    for (int i = 0; i < N_SYS; i++) mem[n + i] = SYS_WORDS[i];
    for (int i = N_DIR; i < MEM_WORDS; i++) mem[i] = $urandom;
    wait (issued == N_TOTAL);
    @(negedge clk);
    report_test("redirect");
    cur_test = "coverage";
    for (int i = 0; i <= 60; i++) begin
      if (i != 51 && i != 52 && i != 55) begin // Unassigned identities
        cur_checks++;
        checks++;
        if (!seen[i]) begin
          errors++;
          cur_errors++;
          $display("[ERROR] coverage: identity %0d was never issued for the directed words", i);
        end
      end
    end
    report_test("coverage");
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d instructions were issued in time", issued, N_TOTAL);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define XLEN 32

`define RESET_PC 32'h0000_0000

// Width of a decoded instruction identity
`define INSTR_ID_W 8

`endif

// File: verilog/fetch_control.sv
`timescale 1ns/10ps

module fetch_control (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imem_req_ready,
  input  logic                      fetch_over,
  input  logic                      issue_ready,
  output frontend_pkg::ctrl_state_t state,
  output logic                      imem_req_valid,
  output logic                      issue_valid,
  output logic                      pc_advance
);

  import frontend_pkg::*;

  ctrl_state_t state_q;

  // DECODE is the WAIT cycle in which the instruction register reports
  // its capture, so the phase follows fetch_over without a cycle of lag
  always_comb begin
    if (state_q == WAIT && fetch_over) begin
      state = DECODE;
    end else begin
      state = state_q;
    end
  end

  assign imem_req_valid = (state == FETCH);
  assign issue_valid    = (state == ISSUE);
  assign pc_advance     = issue_valid && issue_ready; // Issue transfer

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= FETCH;
    end else begin
      case (state)
        FETCH: begin
          if (imem_req_ready) begin
            state_q <= WAIT; // Request accepted
          end
        end
        WAIT: begin
          state_q <= WAIT; // Held until fetch_over
        end
        DECODE: begin
          state_q <= ISSUE;
        end
        ISSUE: begin
          if (issue_ready) begin
            state_q <= FETCH;
          end
        end
        default: begin
          state_q <= FETCH;
        end
      endcase
    end
  end

endmodule

// File: verilog/fetch_decode_top.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module fetch_decode_top (
  input  logic                     clk,
  input  logic                     reset,
  output logic                     imem_req_valid,
  output logic [`XLEN-1:0]         imem_addr,
  input  logic                     imem_req_ready,
  input  logic                     imem_rsp_valid,
  input  logic [`XLEN-1:0]         imem_rsp_data,
  output logic                     issue_valid,
  output frontend_pkg::issue_pkt_t issue,
  input  logic                     issue_ready,
  input  logic                     redirect_valid,
  input  logic [`XLEN-1:0]         redirect_pc
);

  import rv_isa_pkg::*;
  import frontend_pkg::*;

  ctrl_state_t      state;
  logic             pc_advance;
  logic             fetch_over;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] ir;
  instr_id_t        id;
  imm_fmt_t         fmt;
  logic [`XLEN-1:0] imm;

  program_counter u_pc (
    .clk            (clk),
    .reset          (reset),
    .pc_advance     (pc_advance),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pc             (pc)
  );

  fetch_control u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .imem_req_ready (imem_req_ready),
    .fetch_over     (fetch_over),
    .issue_ready    (issue_ready),
    .state          (state),
    .imem_req_valid (imem_req_valid),
    .issue_valid    (issue_valid),
    .pc_advance     (pc_advance)
  );

  instruction_register u_ir (
    .clk        (clk),
    .reset      (reset),
    .state      (state),
    .rsp_valid  (imem_rsp_valid),
    .rsp_data   (imem_rsp_data),
    .ir         (ir),
    .id         (id),
    .fmt        (fmt),
    .fetch_over (fetch_over)
  );

  immediate_gen u_imm (
    .ir  (ir),
    .fmt (fmt),
    .imm (imm)
  );

  assign imem_addr = pc; // pc only moves at the issue transfer

  always_comb begin
    issue.pc  = pc;
    issue.raw = ir;
    issue.id  = id;
    issue.rd  = ir[11:7];
    issue.rs1 = ir[19:15];
    issue.rs2 = ir[24:20];
    issue.imm = imm;
  end

endmodule

// File: verilog/frontend_pkg.sv
`include "core_defs.svh"

package frontend_pkg;

  // Front-end control phases
  typedef enum logic [1:0] {
    FETCH,  // Request on imem
    WAIT,   // Waiting for the response pulse
    DECODE, // Word latched, fetch_over high
    ISSUE   // Packet offered to execute
  } ctrl_state_t;

  // Decoded instruction handed to the execute stage
  typedef struct packed {
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      raw;
    rv_isa_pkg::instr_id_t id;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [`XLEN-1:0]      imm;
  } issue_pkt_t;

endpackage

// File: verilog/immediate_gen.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module immediate_gen (
  input  logic [`XLEN-1:0]     ir,
  input  rv_isa_pkg::imm_fmt_t fmt,
  output logic [`XLEN-1:0]     imm
);

  import rv_isa_pkg::*;

  always_comb begin
    case (fmt)
      IMM_I: begin
        imm = {{(`XLEN-12){ir[31]}}, ir[31:20]};
      end
      IMM_S: begin
        imm = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
      end
      IMM_B: begin // Branch offset, bit 0 always zero
        imm = {{(`XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      IMM_U: begin
        imm = {ir[31:12], 12'b0};
      end
      IMM_J: begin
        imm = {{(`XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      IMM_Z: begin
        imm = {{(`XLEN-5){1'b0}}, ir[19:15]}; // CSR uimm, zero-extended
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: verilog/instruction_register.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module instruction_register (
  input  logic                      clk,
  input  logic                      reset,
  input  frontend_pkg::ctrl_state_t state,
  input  logic                      rsp_valid,
  input  logic [`XLEN-1:0]          rsp_data,
  output logic [`XLEN-1:0]          ir,
  output rv_isa_pkg::instr_id_t     id,
  output rv_isa_pkg::imm_fmt_t      fmt,
  output logic                      fetch_over
);

  import rv_isa_pkg::*;
  import frontend_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  instr_id_t  id_next;
  imm_fmt_t   fmt_next;
  logic       capture;

  assign funct3  = rsp_data[14:12];
  assign funct7  = rsp_data[31:25];
  assign capture = (state == WAIT) && rsp_valid;

  // Format follows the opcode even when funct bits are invalid
  always_comb begin
    id_next  = INSTR_UNKNOWN;
    fmt_next = IMM_NONE;
    case (rsp_data[6:0])
      OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: id_next = INSTR_ADD;
            3'b001: id_next = INSTR_SLL;
            3'b010: id_next = INSTR_SLT;
            3'b011: id_next = INSTR_SLTU;
            3'b100: id_next = INSTR_XOR;
            3'b101: id_next = INSTR_SRL;
            3'b110: id_next = INSTR_OR;
            default: id_next = INSTR_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) id_next = INSTR_SUB;
          else if (funct3 == 3'b101) id_next = INSTR_SRA;
        end else if (funct7 == 7'b0000001) begin
          case (funct3) // RV32M
            3'b000: id_next = INSTR_MUL;
            3'b001: id_next = INSTR_MULH;
            3'b010: id_next = INSTR_MULHSU;
            3'b011: id_next = INSTR_MULHU;
            3'b100: id_next = INSTR_DIV;
            3'b101: id_next = INSTR_DIVU;
            3'b110: id_next = INSTR_REM;
            default: id_next = INSTR_REMU;
          endcase
        end
      end
      OP_IMM: begin
        fmt_next = IMM_I;
        case (funct3)
          3'b000: id_next = INSTR_ADDI;
          3'b010: id_next = INSTR_SLTI;
          3'b011: id_next = INSTR_SLTIU;
          3'b100: id_next = INSTR_XORI;
          3'b110: id_next = INSTR_ORI;
          3'b111: id_next = INSTR_ANDI;
          3'b001: if (funct7 == 7'b0000000) id_next = INSTR_SLLI;
          default: begin // Shift right, arithmetic or logical by funct7
            if (funct7 == 7'b0000000) id_next = INSTR_SRLI;
            else if (funct7 == 7'b0100000) id_next = INSTR_SRAI;
          end
        endcase
      end
      LOAD: begin
        fmt_next = IMM_I;
        case (funct3)
          3'b000: id_next = INSTR_LB;
          3'b001: id_next = INSTR_LH;
          3'b010: id_next = INSTR_LW;
          3'b100: id_next = INSTR_LBU;
          3'b101: id_next = INSTR_LHU;
          default: id_next = INSTR_UNKNOWN;
        endcase
      end
      STORE: begin
        fmt_next = IMM_S;
        case (funct3)
          3'b000: id_next = INSTR_SB;
          3'b001: id_next = INSTR_SH;
          3'b010: id_next = INSTR_SW;
          default: id_next = INSTR_UNKNOWN;
        endcase
      end
      BRANCH: begin
        fmt_next = IMM_B;
        case (funct3)
          3'b000: id_next = INSTR_BEQ;
          3'b001: id_next = INSTR_BNE;
          3'b100: id_next = INSTR_BLT;
          3'b101: id_next = INSTR_BGE;
          3'b110: id_next = INSTR_BLTU;
          3'b111: id_next = INSTR_BGEU;
          default: id_next = INSTR_UNKNOWN;
        endcase
      end
      JAL: begin
        fmt_next = IMM_J;
        id_next  = INSTR_JAL;
      end
      JALR: begin
        fmt_next = IMM_I;
        if (funct3 == 3'b000) id_next = INSTR_JALR;
      end
      LUI: begin
        fmt_next = IMM_U;
        id_next  = INSTR_LUI;
      end
      AUIPC: begin
        fmt_next = IMM_U;
        id_next  = INSTR_AUIPC;
      end
      SYSTEM: begin
        fmt_next = funct3[2] ? IMM_Z : ((funct3 == 3'b000) ? IMM_NONE : IMM_I);
        case (funct3)
          3'b000: begin // Privileged ops match on the whole word, URET included as unknown
            if (rsp_data == 32'h0000_0073) id_next = INSTR_ECALL;
            else if (rsp_data == 32'h0010_0073) id_next = INSTR_EBREAK;
            else if (rsp_data == 32'h1020_0073) id_next = INSTR_SRET;
            else if (rsp_data == 32'h3020_0073) id_next = INSTR_MRET;
            else if (rsp_data == 32'h1050_0073) id_next = INSTR_WFI;
            else if (rsp_data == 32'h1200_0073) id_next = INSTR_SFENCE_VMA;
          end
          3'b001: id_next = INSTR_CSRRW;
          3'b010: id_next = INSTR_CSRRS;
          3'b011: id_next = INSTR_CSRRC;
          3'b101: id_next = INSTR_CSRRWI;
          3'b110: id_next = INSTR_CSRRSI;
          3'b111: id_next = INSTR_CSRRCI;
          default: id_next = INSTR_UNKNOWN;
        endcase
      end
      AMO: begin
        if (funct3 == 3'b010 && rsp_data[31:27] == 5'b00001) id_next = INSTR_AMOSWAP;
      end
      default: id_next = INSTR_UNKNOWN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      ir  <= rsp_data;
      id  <= id_next;
      fmt <= fmt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_over <= 1'b0;
    end else begin
      fetch_over <= capture; // One-cycle pulse after the capture edge
    end
  end

endmodule

// File: verilog/program_counter.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module program_counter (
  input  logic             clk,
  input  logic             reset,
  input  logic             pc_advance,
  input  logic             redirect_valid,
  input  logic [`XLEN-1:0] redirect_pc,
  output logic [`XLEN-1:0] pc
);

  localparam logic [`XLEN-1:0] PC_STEP = 4; // One 32-bit word

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (pc_advance) begin
      if (redirect_valid) begin
        pc <= redirect_pc; // Execute stage took a jump or branch
      end else begin
        pc <= pc + PC_STEP;
      end
    end
  end

endmodule

// File: verilog/rv_isa_pkg.sv
`include "core_defs.svh"

package rv_isa_pkg;

  // Major opcodes, bits 6 to 0 of the instruction word
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011,
    AMO    = 7'b0101111
  } major_opcode_t;

  // Numbered instruction identities; 51, 52 and 55 are not assigned
  typedef enum logic [`INSTR_ID_W-1:0] {
    INSTR_ADD = 0, INSTR_SUB, INSTR_SLL, INSTR_SLT, INSTR_SLTU,
    INSTR_XOR, INSTR_SRL, INSTR_SRA, INSTR_OR, INSTR_AND,
    INSTR_MUL, INSTR_MULH, INSTR_MULHSU, INSTR_MULHU,
    INSTR_DIV, INSTR_DIVU, INSTR_REM, INSTR_REMU,
    INSTR_ADDI, INSTR_SLTI, INSTR_SLTIU, INSTR_XORI, INSTR_ORI, INSTR_ANDI,
    INSTR_SLLI, INSTR_SRLI, INSTR_SRAI,
    INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
    INSTR_SB, INSTR_SH, INSTR_SW,
    INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
    INSTR_JAL, INSTR_JALR, INSTR_LUI, INSTR_AUIPC,
    INSTR_CSRRW, INSTR_CSRRS, INSTR_CSRRC,
    INSTR_CSRRWI, INSTR_CSRRSI, INSTR_CSRRCI,
    INSTR_ECALL = 53, INSTR_EBREAK,
    INSTR_SRET = 56, INSTR_MRET, INSTR_WFI, INSTR_SFENCE_VMA,
    INSTR_AMOSWAP,
    INSTR_UNKNOWN = 255
  } instr_id_t;

  // Immediate formats; IMM_Z is the 5-bit CSR immediate in the rs1 field
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_Z
  } imm_fmt_t;

endpackage
